/* all.f */
+incdir+src
src/ex_op_pkg.sv
src/ex_data_pkg.sv
src/ex_alu.sv
src/ex_branch_unit.sv
src/ex_stage_reg.sv
src/ex_stage_top.sv
bench/tb_ex_stage.sv

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module tb_ex_stage \
    -Mdir obj_dir -o tb_ex_stage > build.log 2>&1 \
    && ./obj_dir/tb_ex_stage > sim.log 2>&1 \
    || { echo "FAIL: build or run error, see build.log and sim.log"; exit 1; }

grep -q "Simulation failed" sim.log \
    && { echo "FAIL: see sim.log"; exit 1; } \
    || { echo "PASS"; exit 0; }

/* bench/tb_ex_stage.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module tb_ex_stage
    import ex_op_pkg::*;
    import ex_data_pkg::*;
();

    localparam int    RST_CYCLES = 16;
    localparam int    RAND_COUNT = 64;
    localparam int    MARGIN     = 20;
    localparam word_t PC0        = 32'h0000_0100;
    localparam word_t NEG1       = 32'hffff_ffff;

    typedef struct {
        ex_req_t   req;
        logic      valid;
        ex_res_t   exp_res;
        logic      exp_valid;
        redirect_t exp_redir;
    } entry_t;

    logic      clk;
    logic      rst_n_i;
    logic      valid_i;
    ex_req_t   req_i;
    logic      valid_o;
    ex_res_t   res_o;
    redirect_t redirect_o;

    entry_t      table_q[$];
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic [31:0] lfsr_state;

    ex_stage_top u_dut (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .req_i      (req_i),
        .valid_o    (valid_o),
        .res_o      (res_o),
        .redirect_o (redirect_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic sub_op_e pick_alu_op(int k);
        case (k)
            0:       return ADD;
            1:       return SUB;
            2:       return SLL;
            3:       return SLT;
            4:       return SLTU;
            5:       return XOR;
            6:       return SRL;
            7:       return SRA;
            8:       return OR;
            default: return AND;
        endcase
    endfunction

    function automatic ex_req_t mk_req(op_class_e cls, sub_op_e sub, word_t pc, word_t imm,
                                       word_t rs1, word_t rs2, reg_addr_t rd);
        ex_req_t r;
        r.pc       = pc;
        r.op_class = cls;
        r.sub_op   = sub;
        r.imm      = imm;
        r.rs1_val  = rs1;
        r.rs2_val  = rs2;
        r.rd       = rd;
        r.wreg     = 1'b1;
        return r;
    endfunction

    // reference for register and immediate alu operations
    function automatic word_t alu_ref(ex_req_t r);
        word_t b;
        b = (r.op_class == OP_IMM) ? r.imm : r.rs2_val;
        case (r.sub_op)
            ADD:     return r.rs1_val + b;
            SUB:     return r.rs1_val - b;
            SLL:     return r.rs1_val << b[4:0];
            SLT:     return ($signed(r.rs1_val) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    return (r.rs1_val < b) ? 32'd1 : 32'd0;
            XOR:     return r.rs1_val ^ b;
            SRL:     return r.rs1_val >> b[4:0];
            SRA:     return word_t'($signed(r.rs1_val) >>> b[4:0]);
            OR:      return r.rs1_val | b;
            AND:     return r.rs1_val & b;
            default: return '0;
        endcase
    endfunction

    function automatic ex_res_t expect_res(ex_req_t r, logic valid, word_t wdata);
        ex_res_t e;
        logic    writer;
        writer = r.op_class inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM, OP_REG};
        e.rd        = r.rd;
        e.wreg      = valid && r.wreg && writer && (r.rd != '0);
        e.wdata     = wdata;
        e.mem_wdata = (r.op_class == OP_STORE) ? r.rs2_val : '0;
        e.mem_op    = r.sub_op;
        e.is_load   = valid && (r.op_class == OP_LOAD);
        e.is_store  = valid && (r.op_class == OP_STORE);
        return e;
    endfunction

    task automatic add_entry(ex_req_t r, logic valid, word_t wdata, logic taken, word_t target);
        entry_t e;
        e.req              = r;
        e.valid            = valid;
        e.exp_res          = expect_res(r, valid, wdata);
        e.exp_valid        = valid;
        e.exp_redir.taken  = valid && taken;
        e.exp_redir.target = target;
        table_q.push_back(e);
    endtask

    task automatic check_valid(logic exp, logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH t=%0t valid_o exp=%b act=%b", $time, exp, act);
        end
    endtask

    task automatic check_res(ex_res_t exp, ex_res_t act);
        logic ok;
        check_count++;
        ok = (act.wreg === exp.wreg) && (act.is_load === exp.is_load)
             && (act.is_store === exp.is_store);
        if (exp.wreg) begin
            ok = ok && (act.rd === exp.rd) && (act.wdata === exp.wdata);
        end
        if (exp.is_load || exp.is_store) begin
            ok = ok && (act.wdata === exp.wdata) && (act.mem_op === exp.mem_op);
        end
        if (exp.is_store) begin
            ok = ok && (act.mem_wdata === exp.mem_wdata);
        end
        if (!ok) begin
            error_count++;
            $display("MISMATCH t=%0t res_o exp=%h act=%h", $time, exp, act);
        end
    endtask

    task automatic check_redirect(redirect_t exp, redirect_t act);
        logic ok;
        check_count++;
        ok = (act.taken === exp.taken);
        if (exp.taken) begin
            ok = ok && (act.target === exp.target);
        end
        if (!ok) begin
            error_count++;
            $display("MISMATCH t=%0t redirect_o exp=%h act=%h", $time, exp, act);
        end
    endtask

    task automatic check_idle();
        check_valid(1'b0, valid_o);
        check_res('0, res_o);
        check_redirect('0, redirect_o);
    endtask

    task automatic check_entry(entry_t e);
        check_valid(e.exp_valid, valid_o);
        check_res(e.exp_res, res_o);
        check_redirect(e.exp_redir, redirect_o);
    endtask

    task automatic build_directed();
        add_entry(mk_req(OP_REG, ADD, PC0, '0, 32'd5, 32'd7, 5'd1), 1'b1, 32'd12, 1'b0, '0);
        add_entry(mk_req(OP_REG, SUB, PC0, '0, 32'd5, 32'd7, 5'd2), 1'b1, 32'hffff_fffe, 1'b0, '0);
        add_entry(mk_req(OP_REG, SLL, PC0, '0, 32'd1, 32'h24, 5'd3), 1'b1, 32'h10, 1'b0, '0);
        add_entry(mk_req(OP_REG, SLT, PC0, '0, 32'hffff_fff0, 32'd1, 5'd4), 1'b1, 32'd1, 1'b0, '0);
        add_entry(mk_req(OP_REG, SLTU, PC0, '0, 32'hffff_fff0, 32'd1, 5'd5), 1'b1, 32'd0, 1'b0, '0);
        add_entry(mk_req(OP_REG, XOR, PC0, '0, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 5'd6), 1'b1,
                  32'hff00_ff00, 1'b0, '0);
        add_entry(mk_req(OP_REG, SRL, PC0, '0, 32'h8000_0000, 32'd4, 5'd7), 1'b1,
                  32'h0800_0000, 1'b0, '0);
        add_entry(mk_req(OP_REG, SRA, PC0, '0, 32'h8000_0000, 32'd4, 5'd8), 1'b1,
                  32'hf800_0000, 1'b0, '0);
        add_entry(mk_req(OP_REG, OR, PC0, '0, 32'h00ff_0000, 32'h0000_00ff, 5'd9), 1'b1,
                  32'h00ff_00ff, 1'b0, '0);
        add_entry(mk_req(OP_REG, AND, PC0, '0, 32'hffff_0000, 32'h0ff0_0ff0, 5'd10), 1'b1,
                  32'h0ff0_0000, 1'b0, '0);
        add_entry(mk_req(OP_IMM, ADD, PC0, NEG1, 32'd100, '0, 5'd11), 1'b1, 32'd99, 1'b0, '0);
        add_entry(mk_req(OP_IMM, SLTU, PC0, NEG1, 32'd3, '0, 5'd12), 1'b1, 32'd1, 1'b0, '0);
        add_entry(mk_req(OP_IMM, SRA, PC0, 32'd8, 32'hffff_ff00, '0, 5'd13), 1'b1, NEG1, 1'b0, '0);
        add_entry(mk_req(OP_LUI, ADD, PC0, 32'h1234_5000, '0, '0, 5'd14), 1'b1,
                  32'h1234_5000, 1'b0, '0);
        add_entry(mk_req(OP_AUIPC, ADD, 32'h1000, 32'h2000, '0, '0, 5'd15), 1'b1,
                  32'h3000, 1'b0, '0);
        // back to back jumps
        add_entry(mk_req(OP_JAL, ADD, 32'h200, 32'h40, '0, '0, 5'd1), 1'b1, 32'h204, 1'b1, 32'h240);
        add_entry(mk_req(OP_JAL, ADD, 32'h204, 32'hffff_fff0, '0, '0, 5'd1), 1'b1,
                  32'h208, 1'b1, 32'h1f4);
        add_entry(mk_req(OP_JALR, ADD, 32'h300, 32'h10, 32'h1001, '0, 5'd1), 1'b1,
                  32'h304, 1'b1, 32'h1010);
        add_entry(mk_req(OP_JAL, ADD, 32'h200, 32'h40, '0, '0, 5'd1), 1'b0, '0, 1'b1, 32'h240);
        // each condition taken then not taken
        add_entry(mk_req(OP_BRANCH, BEQ, 32'h400, 32'h20, 32'd5, 32'd5, 5'd1), 1'b1, '0,
                  1'b1, 32'h420);
        add_entry(mk_req(OP_BRANCH, BEQ, 32'h400, 32'h20, 32'd5, 32'd6, 5'd1), 1'b1, '0, 1'b0, '0);
        add_entry(mk_req(OP_BRANCH, BNE, 32'h400, 32'h20, 32'd5, 32'd6, 5'd1), 1'b1, '0,
                  1'b1, 32'h420);
        add_entry(mk_req(OP_BRANCH, BNE, 32'h400, 32'h20, 32'd5, 32'd5, 5'd1), 1'b1, '0, 1'b0, '0);
        add_entry(mk_req(OP_BRANCH, BLT, 32'h400, 32'h20, NEG1, 32'd1, 5'd1), 1'b1, '0,
                  1'b1, 32'h420);
        add_entry(mk_req(OP_BRANCH, BLT, 32'h400, 32'h20, 32'd1, NEG1, 5'd1), 1'b1, '0, 1'b0, '0);
        add_entry(mk_req(OP_BRANCH, BGE, 32'h400, 32'h20, 32'd1, NEG1, 5'd1), 1'b1, '0,
                  1'b1, 32'h420);
        add_entry(mk_req(OP_BRANCH, BGE, 32'h400, 32'h20, NEG1, 32'd1, 5'd1), 1'b1, '0, 1'b0, '0);
        add_entry(mk_req(OP_BRANCH, BLTU, 32'h400, 32'h20, 32'd1, NEG1, 5'd1), 1'b1, '0,
                  1'b1, 32'h420);
        add_entry(mk_req(OP_BRANCH, BLTU, 32'h400, 32'h20, NEG1, 32'd1, 5'd1), 1'b1, '0, 1'b0, '0);
        add_entry(mk_req(OP_BRANCH, BGEU, 32'h400, 32'h20, NEG1, 32'd1, 5'd1), 1'b1, '0,
                  1'b1, 32'h420);
        add_entry(mk_req(OP_BRANCH, BGEU, 32'h400, 32'h20, 32'd1, NEG1, 5'd1), 1'b1, '0, 1'b0, '0);
        add_entry(mk_req(OP_LOAD, LW, PC0, 32'hffff_fffc, 32'h1000, '0, 5'd5), 1'b1,
                  32'h0ffc, 1'b0, '0);
        add_entry(mk_req(OP_STORE, SW, PC0, 32'd8, 32'h2000, 32'hdead_beef, 5'd7), 1'b1,
                  32'h2008, 1'b0, '0);
        add_entry(mk_req(OP_STORE, SB, PC0, 32'd8, 32'h2000, 32'h55, 5'd7), 1'b0, '0, 1'b0, '0);
        add_entry(mk_req(OP_REG, ADD, PC0, '0, 32'd5, 32'd7, 5'd0), 1'b1, 32'd12, 1'b0, '0);
        add_entry(mk_req(OP_NOP, ADD, PC0, '0, '0, '0, 5'd3), 1'b1, '0, 1'b0, '0);
    endtask

    task automatic build_random();
        ex_req_t    r;
        op_class_e  cls;
        sub_op_e    sub;
        word_t      rs1;
        word_t      rs2;
        logic [11:0] imm12;
        reg_addr_t  rd;
        for (int i = 0; i < RAND_COUNT; i++) begin
            cls = (rand_bits(1) != 0) ? OP_REG : OP_IMM;
            sub = pick_alu_op(int'(rand_bits(4) % 10));
            // no immediate subtract in the encoding
            if (cls == OP_IMM && sub == SUB) begin
                sub = ADD;
            end
            rs1   = rand_bits(32);
            rs2   = rand_bits(32);
            imm12 = 12'(rand_bits(12));
            rd    = reg_addr_t'(rand_bits(5));
            r = mk_req(cls, sub, PC0, {{20{imm12[11]}}, imm12}, rs1, rs2, rd);
            add_entry(r, 1'b1, alu_ref(r), 1'b0, '0);
        end
    endtask

    initial begin
        wait (cycle_limit > 0 && cycle_count >= cycle_limit);
        error_count++;
        $display("timeout after %0d cycles, the test did not reach its end", cycle_count);
        $display("checks=%0d errors=%0d", check_count, error_count);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst_n_i    <= 1'b0;
        valid_i    <= 1'b0;
        req_i      <= '0;
        lfsr_state = 32'h49fd;
        build_directed();
        build_random();
        cycle_limit = RST_CYCLES + table_q.size() + MARGIN;

        // a live jump during reset must stay masked
        for (int k = 0; k < RST_CYCLES; k++) begin
            @(posedge clk);
            if (k < RST_CYCLES - 1) begin
                valid_i <= 1'b1;
                req_i   <= mk_req(OP_JAL, ADD, 32'h80, 32'h10, '0, '0, 5'd1);
            end else begin
                rst_n_i <= 1'b1;
                valid_i <= 1'b0;
            end
            @(negedge clk);
            check_idle();
        end

        for (int i = 0; i <= table_q.size(); i++) begin
            @(posedge clk);
            if (i < table_q.size()) begin
                valid_i <= table_q[i].valid;
                req_i   <= table_q[i].req;
            end else begin
                valid_i <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin
                check_entry(table_q[i-1]);
            end
        end

        $display("checks=%0d errors=%0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* src/ex_stage_top.sv */
`timescale 1ns/1ps

module ex_stage_top
    import ex_data_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      valid_i,
    input  ex_req_t   req_i,
    output logic      valid_o,
    output ex_res_t   res_o,
    output redirect_t redirect_o
);

    word_t     alu_value;
    word_t     link_value;
    redirect_t redirect_next;

    ex_alu u_alu (
        .req_i       (req_i),
        .alu_value_o (alu_value)
    );

    // jumps and branches, resolved in this stage
    ex_branch_unit u_branch (
        .req_i        (req_i),
        .link_value_o (link_value),
        .redirect_o   (redirect_next)
    );

    // ex/mem boundary
    ex_stage_reg u_reg (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .req_i        (req_i),
        .alu_value_i  (alu_value),
        .link_value_i (link_value),
        .redirect_i   (redirect_next),
        .valid_o      (valid_o),
        .res_o        (res_o),
        .redirect_o   (redirect_o)
    );

endmodule

/* src/ex_stage_reg.sv */
`timescale 1ns/1ps

module ex_stage_reg
    import ex_op_pkg::*;
    import ex_data_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      valid_i,
    input  ex_req_t   req_i,
    input  word_t     alu_value_i,
    input  word_t     link_value_i,
    input  redirect_t redirect_i,
    output logic      valid_o,
    output ex_res_t   res_o,
    output redirect_t redirect_o
);

    logic  is_jump;
    logic  class_writes;
    logic  wreg_next;
    logic  is_load_next;
    logic  is_store_next;
    word_t wdata_next;

    assign is_jump       = req_i.op_class inside {OP_JAL, OP_JALR};
    assign is_load_next  = req_i.op_class == OP_LOAD;
    assign is_store_next = req_i.op_class == OP_STORE;

    // branch, store, nop and unknown classes never write
    assign class_writes = req_i.op_class inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
                                                 OP_LOAD, OP_IMM, OP_REG};
    assign wreg_next    = req_i.wreg && class_writes && (req_i.rd != '0);

    assign wdata_next = is_jump ? link_value_i : alu_value_i;

    always_ff @(posedge clk) begin
        res_o.rd          <= req_i.rd;
        res_o.wdata       <= wdata_next;
        res_o.mem_op      <= req_i.sub_op;
        redirect_o.target <= redirect_i.target;
        if (is_store_next) begin
            res_o.mem_wdata <= req_i.rs2_val;
        end else begin
            res_o.mem_wdata <= '0;
        end

        if (!rst_n_i) begin
            valid_o          <= 1'b0;
            res_o.wreg       <= 1'b0;
            res_o.is_load    <= 1'b0;
            res_o.is_store   <= 1'b0;
            redirect_o.taken <= 1'b0;
        end else begin
            valid_o          <= valid_i;
            res_o.wreg       <= valid_i && wreg_next;
            res_o.is_load    <= valid_i && is_load_next;
            res_o.is_store   <= valid_i && is_store_next;
            redirect_o.taken <= valid_i && redirect_i.taken;
        end
    end

    // only jumps and branches may flush the front end
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (valid_i && redirect_i.taken) |-> (is_jump || req_i.op_class == OP_BRANCH))
    else $error("ex_stage_reg: redirect from a non control instruction");

    // fetch only ever sees halfword aligned targets
    assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_o.taken |-> !redirect_o.target[0])
    else $error("ex_stage_reg: misaligned redirect target");

endmodule

/* src/ex_branch_unit.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_branch_unit
    import ex_op_pkg::*;
    import ex_data_pkg::*;
(
    input  ex_req_t   req_i,
    output word_t     link_value_o,
    output redirect_t redirect_o
);

    logic  eq;
    logic  lt_s;
    logic  lt_u;
    logic  cond;
    word_t jalr_sum;

    assign eq   = req_i.rs1_val == req_i.rs2_val;
    assign lt_s = $signed(req_i.rs1_val) < $signed(req_i.rs2_val);
    assign lt_u = req_i.rs1_val < req_i.rs2_val;

    always_comb begin
        case (req_i.sub_op)
            BEQ:     cond = eq;
            BNE:     cond = !eq;
            BLT:     cond = lt_s;
            BGE:     cond = !lt_s;
            BLTU:    cond = lt_u;
            BGEU:    cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    assign jalr_sum = req_i.rs1_val + req_i.imm;

    always_comb begin
        redirect_o.taken  = 1'b0;
        redirect_o.target = req_i.pc + req_i.imm;
        case (req_i.op_class)
            OP_JAL: begin
                redirect_o.taken = 1'b1;
            end
            OP_JALR: begin
                redirect_o.taken  = 1'b1;
                // target is halfword aligned
                redirect_o.target = {jalr_sum[`XLEN-1:1], 1'b0};
            end
            OP_BRANCH: begin
                redirect_o.taken = cond;
            end
            default: begin
                redirect_o.taken = 1'b0;
            end
        endcase
    end

    // return address for jal and jalr
    assign link_value_o = req_i.pc + word_t'(`INSTR_BYTES);

endmodule

/* src/ex_alu.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_alu
    import ex_op_pkg::*;
    import ex_data_pkg::*;
(
    input  ex_req_t req_i,
    output word_t   alu_value_o
);

    word_t               op_b;
    logic [`SHAMT_W-1:0] shamt;
    logic                lt_s;
    logic                lt_u;
    word_t               func_value;

    // immediate forms and address generation take imm
    always_comb begin
        if (req_i.op_class inside {OP_IMM, OP_LOAD, OP_STORE}) begin
            op_b = req_i.imm;
        end else begin
            op_b = req_i.rs2_val;
        end
    end

    assign shamt = op_b[`SHAMT_W-1:0];
    assign lt_s  = $signed(req_i.rs1_val) < $signed(op_b);
    assign lt_u  = req_i.rs1_val < op_b;

    always_comb begin
        case (req_i.sub_op)
            ADD:  func_value = req_i.rs1_val + op_b;
            // no subi, the immediate form falls back to add
            SUB: begin
                if (req_i.op_class == OP_REG) begin
                    func_value = req_i.rs1_val - op_b;
                end else begin
                    func_value = req_i.rs1_val + op_b;
                end
            end
            SLL:  func_value = req_i.rs1_val << shamt;
            SLT:  func_value = {{(`XLEN-1){1'b0}}, lt_s};
            SLTU: func_value = {{(`XLEN-1){1'b0}}, lt_u};
            XOR:  func_value = req_i.rs1_val ^ op_b;
            SRL:  func_value = req_i.rs1_val >> shamt;
            SRA:  func_value = word_t'($signed(req_i.rs1_val) >>> shamt);
            OR:   func_value = req_i.rs1_val | op_b;
            AND:  func_value = req_i.rs1_val & op_b;
            default: func_value = '0;
        endcase
    end

    always_comb begin
        case (req_i.op_class)
            OP_LUI:   alu_value_o = req_i.imm;
            OP_AUIPC: alu_value_o = req_i.pc + req_i.imm;
            // effective address
            OP_LOAD, OP_STORE: begin
                alu_value_o = req_i.rs1_val + op_b;
            end
            OP_IMM, OP_REG: begin
                alu_value_o = func_value;
            end
            default: alu_value_o = '0;
        endcase
    end

    // decode must never hand over a class outside the encoding
    always_comb begin
        if (!$isunknown(req_i.op_class)) begin
            assert (req_i.op_class inside {OP_NOP, OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
                                           OP_BRANCH, OP_LOAD, OP_STORE, OP_IMM, OP_REG})
            else $error("ex_alu: undefined op_class %0d", req_i.op_class);
        end
    end

endmodule

/* src/ex_data_pkg.sv */
`include "ex_macros.svh"

package ex_data_pkg;

    import ex_op_pkg::*;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // one issued instruction from decode
    typedef struct packed {
        word_t     pc;
        op_class_e op_class;
        sub_op_e   sub_op;
        word_t     imm;
        word_t     rs1_val;
        word_t     rs2_val;
        reg_addr_t rd;
        logic      wreg;
    } ex_req_t;

    // handed to the memory stage
    // wdata holds the memory address for loads and stores
    typedef struct packed {
        reg_addr_t rd;
        logic      wreg;
        word_t     wdata;
        word_t     mem_wdata;
        sub_op_e   mem_op;
        logic      is_load;
        logic      is_store;
    } ex_res_t;

    // pc change request towards fetch
    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

/* src/ex_op_pkg.sv */
`include "ex_macros.svh"

package ex_op_pkg;

    // instruction class as handed over by decode
    typedef enum logic [`OP_CLASS_W-1:0] {
        OP_NOP    = 4'd0,
        OP_LUI    = 4'd1,
        OP_AUIPC  = 4'd2,
        OP_JAL    = 4'd3,
        OP_JALR   = 4'd4,
        OP_BRANCH = 4'd5,
        OP_LOAD   = 4'd6,
        OP_STORE  = 4'd7,
        OP_IMM    = 4'd8,
        OP_REG    = 4'd9
    } op_class_e;

    // alu functions low, branch kinds and memory widths above
    typedef enum logic [`SUB_OP_W-1:0] {
        ADD  = 6'h00,
        SUB  = 6'h01,
        SLL  = 6'h02,
        SLT  = 6'h03,
        SLTU = 6'h04,
        XOR  = 6'h05,
        SRL  = 6'h06,
        SRA  = 6'h07,
        OR   = 6'h08,
        AND  = 6'h09,
        BEQ  = 6'h10,
        BNE  = 6'h11,
        BLT  = 6'h12,
        BGE  = 6'h13,
        BLTU = 6'h14,
        BGEU = 6'h15,
        LB   = 6'h20,
        LH   = 6'h21,
        LW   = 6'h22,
        LBU  = 6'h23,
        LHU  = 6'h24,
        SB   = 6'h28,
        SH   = 6'h29,
        SW   = 6'h2a
    } sub_op_e;

endpackage

/* src/ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// data and address width
`define XLEN 32

// register file index
`define REG_ADDR_W 5

// shift amount, low bits of the second operand
`define SHAMT_W 5

// instruction size, used for the link value
`define INSTR_BYTES 4

// encoding widths of the operation fields
`define OP_CLASS_W 4
`define SUB_OP_W 6

`endif
